// ==== include/exch_settings.svh ====
`ifndef EXCH_SETTINGS_SVH
`define EXCH_SETTINGS_SVH

// Width of one message word
`define EXCH_DATA_W 32

// Words held by each ingress store and by the outbound buffer
`define EXCH_MAX_WORDS 16

// Bits needed for a length from 0 to EXCH_MAX_WORDS
`define EXCH_LEN_W 5

// Bits needed for an index into a store
`define EXCH_ADDR_W 4

// Seed of the whitening keystream, must not be zero
`define EXCH_KEY 32'h9e37_79b9

`endif

// ==== hdl/exch_pkg.sv ====
`include "exch_settings.svh"

package exch_pkg;

	// One data word as carried between the parties
	typedef logic [`EXCH_DATA_W-1:0] exch_word_t;

	// Message length, counts up to and including EXCH_MAX_WORDS
	typedef logic [`EXCH_LEN_W-1:0] exch_len_t;

	// Index into an ingress store or the outbound buffer
	typedef logic [`EXCH_ADDR_W-1:0] exch_addr_t;

	// Direction of the message currently in the exchange
	typedef enum logic {
		DIR_TO_ACC  = 1'b0, // Initiator is the source
		DIR_TO_INIT = 1'b1 // Acceptor is the source
	} exch_dir_e;

	// Word format on every party port
	typedef struct packed {
		exch_word_t data;
		logic       last; // Closes the message
	} exch_beat_t;

endpackage

// ==== hdl/msg_ingress.sv ====
`timescale 1ns/1ns
`include "exch_settings.svh"

module msg_ingress #(
	parameter type beat_t = exch_pkg::exch_beat_t
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                wr_valid_i,
	input  beat_t               wr_i,
	output logic                ready_o,
	output logic                pend_o,
	output exch_pkg::exch_len_t  len_o,
	input  exch_pkg::exch_addr_t rd_addr_i,
	output exch_pkg::exch_word_t rd_data_o,
	input  logic                release_i
);
	import exch_pkg::*;

	exch_word_t mem [`EXCH_MAX_WORDS];
	exch_len_t  wr_cnt;
	exch_len_t  len_q;
	logic       full;
	logic       take;
	logic       room;

	assign take = wr_valid_i && !full;
	assign room = (wr_cnt < `EXCH_MAX_WORDS); // Words past the depth are dropped

	assign ready_o   = ~full;
	assign pend_o    = full;
	assign len_o     = len_q;
	assign rd_data_o = mem[rd_addr_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			full   <= 1'b0;
			wr_cnt <= '0;
			len_q  <= '0;
		end else if (release_i) begin
			full <= 1'b0; // Transform has read the message, reopen the store
		end else if (take) begin
			if (wr_i.last) begin
				full   <= 1'b1;
				wr_cnt <= '0;
				// Length saturates at the depth so a long message is truncated
				len_q  <= room ? exch_len_t'(wr_cnt + 1'b1) : wr_cnt;
			end else if (room) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && room) begin
			mem[exch_addr_t'(wr_cnt)] <= wr_i.data;
		end
	end

endmodule

// ==== hdl/exch_sync.sv ====
`timescale 1ns/1ns

module exch_sync (
	input  logic                clk,
	input  logic                rst,
	input  logic                end_init_i,
	input  logic                end_acc_i,
	input  logic                status_i,
	input  logic                all_sent_i,
	output logic                xform_start_o,
	output exch_pkg::exch_dir_e dir_o,
	output logic                new_message_init_o,
	output logic                new_message_acc_o,
	output logic                send_to_acc_o,
	output logic                send_to_init_o
);
	import exch_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_wait_acc,  // Transform running on an initiator message
		st_wait_init, // Transform running on an acceptor message
		st_send_acc,
		st_send_init
	} state_t;

	state_t    state;
	state_t    next_state;
	exch_dir_e dir_q;
	exch_dir_e dir_sel;

	assign dir_sel = end_init_i ? DIR_TO_ACC : DIR_TO_INIT; // Initiator wins a tie

	// The transform samples the direction together with the start pulse
	assign dir_o = (state == st_idle) ? dir_sel : dir_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			dir_q <= DIR_TO_ACC;
		end else begin
			state <= next_state;
			if (xform_start_o) begin
				dir_q <= dir_sel;
			end
		end
	end

	always_comb begin
		xform_start_o      = 1'b0;
		new_message_init_o = 1'b0;
		new_message_acc_o  = 1'b0;
		send_to_acc_o      = 1'b0;
		send_to_init_o     = 1'b0;
		next_state         = state;
		case (state)
			st_idle: begin
				if (end_init_i) begin
					xform_start_o = 1'b1;
					next_state    = st_wait_acc;
				end else if (end_acc_i) begin
					xform_start_o = 1'b1;
					next_state    = st_wait_init;
				end
			end
			st_wait_acc: begin
				if (status_i) begin
					new_message_acc_o = 1'b1; // Announce to the receiver
					next_state        = st_send_acc;
				end
			end
			st_wait_init: begin
				if (status_i) begin
					new_message_init_o = 1'b1;
					next_state         = st_send_init;
				end
			end
			st_send_acc: begin
				if (all_sent_i) begin
					next_state = st_idle;
				end else begin
					send_to_acc_o = 1'b1;
				end
			end
			st_send_init: begin
				if (all_sent_i) begin
					next_state = st_idle;
				end else begin
					send_to_init_o = 1'b1;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

endmodule

// ==== hdl/msg_transform.sv ====
`timescale 1ns/1ns
`include "exch_settings.svh"

module msg_transform (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  exch_pkg::exch_dir_e  dir_i,
	input  exch_pkg::exch_len_t  init_len_i,
	input  exch_pkg::exch_len_t  acc_len_i,
	input  exch_pkg::exch_word_t init_data_i,
	input  exch_pkg::exch_word_t acc_data_i,
	output exch_pkg::exch_addr_t rd_addr_o,
	output logic                 release_init_o,
	output logic                 release_acc_o,
	output logic                 status_o,
	output exch_pkg::exch_len_t  out_len_o,
	input  exch_pkg::exch_addr_t out_addr_i,
	output exch_pkg::exch_word_t out_data_o
);
	import exch_pkg::*;

	exch_word_t out_mem [`EXCH_MAX_WORDS];
	exch_word_t ks;
	exch_word_t ks_nxt;
	exch_word_t src_data;
	exch_len_t  src_len;
	exch_len_t  cnt;
	exch_len_t  len_q;
	logic       busy;
	logic       last_word;
	logic       status_q;

	// One xorshift32 step
	function automatic exch_word_t xorshift32(input exch_word_t x);
		exch_word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign src_len   = (dir_i == DIR_TO_ACC) ? init_len_i : acc_len_i;
	assign src_data  = (dir_i == DIR_TO_ACC) ? init_data_i : acc_data_i;
	assign ks_nxt    = xorshift32(ks);
	assign last_word = busy && (cnt == len_q - 1'b1);

	assign rd_addr_o      = exch_addr_t'(cnt);
	assign status_o       = status_q;
	assign release_init_o = status_q && (dir_i == DIR_TO_ACC); // Only the source is reopened
	assign release_acc_o  = status_q && (dir_i == DIR_TO_INIT);
	assign out_len_o      = len_q;
	assign out_data_o     = out_mem[out_addr_i];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			status_q <= 1'b0;
			cnt      <= '0;
			len_q    <= '0;
		end else begin
			status_q <= last_word;
			if (start_i) begin
				busy  <= 1'b1;
				cnt   <= '0;
				len_q <= src_len;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (last_word) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Keystream restarts from the key for every message
	always_ff @(posedge clk) begin
		if (start_i) begin
			ks <= `EXCH_KEY;
		end else if (busy) begin
			ks                         <= ks_nxt;
			out_mem[exch_addr_t'(cnt)] <= src_data ^ ks_nxt;
		end
	end

endmodule

// ==== hdl/msg_egress.sv ====
`timescale 1ns/1ns

module msg_egress (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 new_msg_i,
	input  logic                 send_to_acc_i,
	input  logic                 send_to_init_i,
	input  exch_pkg::exch_len_t  len_i,
	output exch_pkg::exch_addr_t rd_addr_o,
	input  exch_pkg::exch_word_t rd_data_i,
	output logic                 all_sent_o,
	output exch_pkg::exch_beat_t acc_rx_o,
	output exch_pkg::exch_beat_t init_rx_o,
	output logic                 acc_rx_valid_o,
	output logic                 init_rx_valid_o
);
	import exch_pkg::*;

	exch_len_t  idx;
	exch_beat_t beat;
	logic       send_act;
	logic       word_ok;
	logic       all_sent_q;

	assign send_act = send_to_acc_i | send_to_init_i;
	assign word_ok  = send_act && (idx < len_i);

	assign rd_addr_o = exch_addr_t'(idx);

	always_comb begin
		beat.data = rd_data_i;
		beat.last = (idx == len_i - 1'b1); // Final word of the message
	end

	assign acc_rx_o        = beat;
	assign init_rx_o       = beat;
	assign acc_rx_valid_o  = word_ok && send_to_acc_i;
	assign init_rx_valid_o = word_ok && send_to_init_i;
	assign all_sent_o      = all_sent_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			idx        <= '0;
			all_sent_q <= 1'b0;
		end else if (new_msg_i) begin
			idx        <= '0;
			all_sent_q <= 1'b0;
		end else if (word_ok) begin
			idx        <= idx + 1'b1;
			all_sent_q <= (exch_len_t'(idx + 1'b1) == len_i); // Index reaches the length
		end
	end

endmodule

// ==== hdl/exch_top.sv ====
`timescale 1ns/1ns

module exch_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 init_wr_valid_i,
	input  exch_pkg::exch_beat_t init_wr_i,
	output logic                 init_ready_o,
	input  logic                 acc_wr_valid_i,
	input  exch_pkg::exch_beat_t acc_wr_i,
	output logic                 acc_ready_o,
	output logic                 acc_new_msg_o,
	output logic                 init_new_msg_o,
	output exch_pkg::exch_beat_t acc_rx_o,
	output logic                 acc_rx_valid_o,
	output exch_pkg::exch_beat_t init_rx_o,
	output logic                 init_rx_valid_o
);
	import exch_pkg::*;

	logic       init_pend;
	logic       acc_pend;
	exch_len_t  init_len;
	exch_len_t  acc_len;
	exch_word_t init_rd_data;
	exch_word_t acc_rd_data;
	exch_addr_t xform_rd_addr;
	logic       release_init;
	logic       release_acc;
	logic       xform_start;
	exch_dir_e  dir;
	logic       status;
	exch_len_t  out_len;
	exch_addr_t out_addr;
	exch_word_t out_data;
	logic       all_sent;
	logic       send_to_acc;
	logic       send_to_init;

	msg_ingress #(.beat_t(exch_beat_t)) init_ingress (
		.clk       (clk),
		.rst       (rst),
		.wr_valid_i(init_wr_valid_i),
		.wr_i      (init_wr_i),
		.ready_o   (init_ready_o),
		.pend_o    (init_pend),
		.len_o     (init_len),
		.rd_addr_i (xform_rd_addr),
		.rd_data_o (init_rd_data),
		.release_i (release_init)
	);

	msg_ingress #(.beat_t(exch_beat_t)) acc_ingress (
		.clk       (clk),
		.rst       (rst),
		.wr_valid_i(acc_wr_valid_i),
		.wr_i      (acc_wr_i),
		.ready_o   (acc_ready_o),
		.pend_o    (acc_pend),
		.len_o     (acc_len),
		.rd_addr_i (xform_rd_addr),
		.rd_data_o (acc_rd_data),
		.release_i (release_acc)
	);

	exch_sync exch_sync_i (
		.clk               (clk),
		.rst               (rst),
		.end_init_i        (init_pend),
		.end_acc_i         (acc_pend),
		.status_i          (status),
		.all_sent_i        (all_sent),
		.xform_start_o     (xform_start),
		.dir_o             (dir),
		.new_message_init_o(init_new_msg_o),
		.new_message_acc_o (acc_new_msg_o),
		.send_to_acc_o     (send_to_acc),
		.send_to_init_o    (send_to_init)
	);

	msg_transform msg_transform_i (
		.clk           (clk),
		.rst           (rst),
		.start_i       (xform_start),
		.dir_i         (dir),
		.init_len_i    (init_len),
		.acc_len_i     (acc_len),
		.init_data_i   (init_rd_data),
		.acc_data_i    (acc_rd_data),
		.rd_addr_o     (xform_rd_addr),
		.release_init_o(release_init),
		.release_acc_o (release_acc),
		.status_o      (status),
		.out_len_o     (out_len),
		.out_addr_i    (out_addr),
		.out_data_o    (out_data)
	);

	// Either announcement restarts the outbound stream
	msg_egress msg_egress_i (
		.clk            (clk),
		.rst            (rst),
		.new_msg_i      (init_new_msg_o | acc_new_msg_o),
		.send_to_acc_i  (send_to_acc),
		.send_to_init_i (send_to_init),
		.len_i          (out_len),
		.rd_addr_o      (out_addr),
		.rd_data_i      (out_data),
		.all_sent_o     (all_sent),
		.acc_rx_o       (acc_rx_o),
		.init_rx_o      (init_rx_o),
		.acc_rx_valid_o (acc_rx_valid_o),
		.init_rx_valid_o(init_rx_valid_o)
	);

endmodule

// ==== tb/exch_chk.sv ====
`timescale 1ns/1ns

module exch_chk #(
	parameter bit pulse_chk = 1'b1 // Zero where the bound module has no announcements
) (
	input logic clk,
	input logic rst,
	input logic excl_a_i,
	input logic excl_b_i,
	input logic pulse_a_i,
	input logic pulse_b_i
);
	int unsigned err_cnt = 0; // Read by the testbench monitor

	excl_never_both: assert property (@(posedge clk) disable iff (rst) !(excl_a_i && excl_b_i))
	else begin
		$error("%m: both exclusive strobes are high in the same cycle");
		err_cnt++;
	end

	if (pulse_chk) begin : g_pulse
		// An announcement lasts one cycle and opens the send phase of its direction
		pulse_a_then_send: assert property (@(posedge clk) disable iff (rst)
			pulse_a_i |=> (!pulse_a_i && excl_a_i))
		else begin
			$error("%m: first pulse is longer than one cycle or not followed by its enable");
			err_cnt++;
		end

		pulse_b_then_send: assert property (@(posedge clk) disable iff (rst)
			pulse_b_i |=> (!pulse_b_i && excl_b_i))
		else begin
			$error("%m: second pulse is longer than one cycle or not followed by its enable");
			err_cnt++;
		end
	end

endmodule

// ==== tb/exch_tb.sv ====
`timescale 1ns/1ns
`include "exch_settings.svh"

module exch_tb;
	import exch_pkg::*;

	localparam int NUM_MSGS    = 24;
	localparam int CYCLE_LIMIT = NUM_MSGS * (`EXCH_MAX_WORDS * 2 + 8) + 1000;

	logic        clk = 1'b0;
	logic        rst;
	logic        init_wr_valid;
	exch_beat_t  init_wr;
	logic        init_ready;
	logic        acc_wr_valid;
	exch_beat_t  acc_wr;
	logic        acc_ready;
	logic        acc_new_msg;
	logic        init_new_msg;
	exch_beat_t  acc_rx;
	logic        acc_rx_valid;
	exch_beat_t  init_rx;
	logic        init_rx_valid;
	logic [31:0] rng = 32'hffd3_41d3;
	int          cyc = 0;
	exch_beat_t  exp_to_acc[$];
	exch_beat_t  exp_to_init[$];
	exch_len_t   lens_to_acc[$];
	exch_len_t   lens_to_init[$];
	exch_len_t   rcv_cnt[2]; // Index 0 is the acceptor port, 1 the initiator port
	logic        announced[2];

	exch_top exch_top_i (
		.clk            (clk),
		.rst            (rst),
		.init_wr_valid_i(init_wr_valid),
		.init_wr_i      (init_wr),
		.init_ready_o   (init_ready),
		.acc_wr_valid_i (acc_wr_valid),
		.acc_wr_i       (acc_wr),
		.acc_ready_o    (acc_ready),
		.acc_new_msg_o  (acc_new_msg),
		.init_new_msg_o (init_new_msg),
		.acc_rx_o       (acc_rx),
		.acc_rx_valid_o (acc_rx_valid),
		.init_rx_o      (init_rx),
		.init_rx_valid_o(init_rx_valid)
	);

	bind exch_sync exch_chk sync_chk (
		.clk      (clk),
		.rst      (rst),
		.excl_a_i (send_to_acc_o),
		.excl_b_i (send_to_init_o),
		.pulse_a_i(new_message_acc_o),
		.pulse_b_i(new_message_init_o)
	);
	bind msg_egress exch_chk #(.pulse_chk(1'b0)) egress_chk (
		.clk      (clk),
		.rst      (rst),
		.excl_a_i (acc_rx_valid_o),
		.excl_b_i (init_rx_valid_o),
		.pulse_a_i(1'b0),
		.pulse_b_i(1'b0)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int assert_errors();
		return exch_top_i.exch_sync_i.sync_chk.err_cnt
			+ exch_top_i.msg_egress_i.egress_chk.err_cnt;
	endfunction

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_beat(input string name, input exch_beat_t got, input exch_beat_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got data=%h last=%b expected data=%h last=%b",
				$time, name, got.data, got.last, exp.data, exp.last);
			stop_run();
		end
	endtask

	task automatic check_len(input string name, input exch_len_t got, input exch_len_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic draw(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic draw_len(output int len);
		logic [31:0] r;
		draw(r);
		len = 1 + int'(r % `EXCH_MAX_WORDS);
	endtask

	// The shorter message starts later so that both close in the same cycle
	task automatic send_msgs(input int len_init, input int len_acc);
		int          n;
		logic [31:0] r;
		logic [31:0] ks_init;
		logic [31:0] ks_acc;
		exch_beat_t  b;
		n = (len_init > len_acc) ? len_init : len_acc;
		ks_init = `EXCH_KEY;
		ks_acc = `EXCH_KEY;
		if (len_init > 0)
			lens_to_acc.push_back(exch_len_t'(len_init));
		if (len_acc > 0)
			lens_to_init.push_back(exch_len_t'(len_acc));
		do begin
			@(negedge clk);
		end while ((len_init > 0 && !init_ready) || (len_acc > 0 && !acc_ready));
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
			init_wr_valid <= (k >= n - len_init);
			acc_wr_valid <= (k >= n - len_acc);
			if (k >= n - len_init) begin
				draw(r);
				ks_init = xorshift(ks_init);
				b.data = r;
				b.last = (k == n - 1);
				init_wr <= b;
				b.data = r ^ ks_init; // Whitened as it must appear at the acceptor
				exp_to_acc.push_back(b);
			end
			if (k >= n - len_acc) begin
				draw(r);
				ks_acc = xorshift(ks_acc);
				b.data = r;
				b.last = (k == n - 1);
				acc_wr <= b;
				b.data = r ^ ks_acc;
				exp_to_init.push_back(b);
			end
		end
		@(posedge clk);
		init_wr_valid <= 1'b0;
		acc_wr_valid <= 1'b0;
	endtask

	task automatic take_beat(input int port, input exch_beat_t got);
		exch_beat_t exp;
		string      name;
		name = (port == 0) ? "acc_rx_o" : "init_rx_o";
		if ((port == 0) ? (exp_to_acc.size() == 0) : (exp_to_init.size() == 0)) begin
			$display("A word arrived on %s while no message for that port was outstanding", name);
			stop_run();
		end
		if (rcv_cnt[port] == 0 && !announced[port]) begin
			$display("A message started on %s without a new-message pulse before it", name);
			stop_run();
		end
		if (port == 0)
			exp = exp_to_acc.pop_front();
		else
			exp = exp_to_init.pop_front();
		check_beat(name, got, exp);
		rcv_cnt[port]++;
	endtask

	// A message leaves as one unbroken run of valid words, counted apart from its last flag
	task automatic close_message(input int port);
		exch_len_t exp_len;
		string     name;
		name = (port == 0) ? "acc_rx_o" : "init_rx_o";
		if (port == 0)
			exp_len = lens_to_acc.pop_front();
		else
			exp_len = lens_to_init.pop_front();
		check_len({name, " word count"}, rcv_cnt[port], exp_len);
		rcv_cnt[port] = '0;
		announced[port] = 1'b0;
	endtask

	task automatic wait_delivered();
		while (exp_to_acc.size() != 0 || exp_to_init.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // Let the controller settle back in idle
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with messages still outstanding", cyc);
			stop_run();
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (acc_new_msg)
				announced[0] = 1'b1;
			if (init_new_msg)
				announced[1] = 1'b1;
			if (acc_rx_valid)
				take_beat(0, acc_rx);
			else if (rcv_cnt[0] != 0)
				close_message(0);
			if (init_rx_valid)
				take_beat(1, init_rx);
			else if (rcv_cnt[1] != 0)
				close_message(1);
			if (assert_errors() != 0) begin
				$display("A bound assertion on the controller or the egress stage failed");
				stop_run();
			end
		end
	end

	initial begin
		int          len_a;
		int          len_b;
		logic [31:0] r;
		rst = 1'b1;
		init_wr_valid = 1'b0;
		init_wr = '0;
		acc_wr_valid = 1'b0;
		acc_wr = '0;
		rcv_cnt = '{default: '0};
		announced = '{default: 1'b0};
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_level("init_ready_o", init_ready, 1'b1);
		check_level("acc_ready_o", acc_ready, 1'b1);
		check_level("acc_new_msg_o", acc_new_msg, 1'b0);
		check_level("init_new_msg_o", init_new_msg, 1'b0);
		check_level("acc_rx_valid_o", acc_rx_valid, 1'b0);
		check_level("init_rx_valid_o", init_rx_valid, 1'b0);

		draw_len(len_a);
		send_msgs(len_a, 0);
		wait_delivered();
		draw_len(len_b);
		send_msgs(0, len_b);
		wait_delivered();

		// Both close together, so the initiator goes first
		draw_len(len_a);
		draw_len(len_b);
		send_msgs(len_a, len_b);
		do begin
			@(negedge clk);
		end while (!init_ready);
		check_level("acc_ready_o", acc_ready, 1'b0);
		check_level("acc_rx_valid_o", acc_rx_valid, 1'b1);
		do begin
			@(negedge clk);
		end while (!acc_ready);
		check_level("init_rx_valid_o", init_rx_valid, 1'b1);
		if (exp_to_acc.size() != 0) begin
			$display("The acceptor message was released before the initiator message was out");
			stop_run();
		end
		wait_delivered();

		send_msgs(`EXCH_MAX_WORDS, 0);
		wait_delivered();
		send_msgs(0, `EXCH_MAX_WORDS);
		wait_delivered();
		send_msgs(1, 1);
		for (int i = 0; i < 8; i++) begin
			draw(r);
			draw_len(len_a);
			draw_len(len_b);
			case (r % 3)
				0: send_msgs(len_a, 0);
				1: send_msgs(0, len_b);
				default: send_msgs(len_a, len_b);
			endcase
		end
		wait_delivered();

		if (assert_errors() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("A bound assertion failed during the run");
			stop_run();
		end
	end

endmodule

// ==== sources.f ====
+incdir+include
hdl/exch_pkg.sv
hdl/msg_ingress.sv
hdl/exch_sync.sv
hdl/msg_transform.sv
hdl/msg_egress.sv
hdl/exch_top.sv
tb/exch_chk.sv
tb/exch_tb.sv

// ==== Bender.yml ====
package:
  name: exch

export_include_dirs:
  - include

sources:
  - hdl/exch_pkg.sv
  - hdl/msg_ingress.sv
  - hdl/exch_sync.sv
  - hdl/msg_transform.sv
  - hdl/msg_egress.sv
  - hdl/exch_top.sv
  - target: test
    files:
      - tb/exch_chk.sv
      - tb/exch_tb.sv
